// ==== can_rx.f ====
+incdir+tb
common/can_rx_pkg.sv
hdl/can_destuffer.sv
frame_parser/can_crc15.sv
frame_parser/can_field_parser.sv
hdl/can_frame_buffer.sv
hdl/can_rx.sv
tb/can_rx_sva.sv
tb/can_rx_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the can_rx testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -Wno-fatal \
		-f can_rx.f --top-module can_rx_tb -Mdir obj_dir \
	&& ./obj_dir/Vcan_rx_tb | tee /dev/stderr \
		| grep -F "Simulation completed successfully" > /dev/null \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

// ==== tb/can_frame_builder.svh ====
`ifndef CAN_FRAME_BUILDER_SVH
`define CAN_FRAME_BUILDER_SVH

// Unstuffed bits, SOF through the last CRC bit
logic raw_bits[$];
// Bits as they go onto the bus
logic wire_bits[$];
// Position of the first data bit in raw_bits
int raw_data_pos;

// Bytes in the data field, DLC above 8 means 8
function automatic int data_bytes(logic [3:0] dlc, logic rtr);
	if (rtr)
		return 0;
	if (dlc > 4'd8)
		return 8;
	return int'(dlc);
endfunction

// Low count bits of value, MSB first
function automatic void push_raw_field(logic [63:0] value, int count);
	for (int i = count - 1; i >= 0; i--)
		raw_bits.push_back(value[i]);
endfunction

// CAN CRC-15 over everything in raw_bits so far
function automatic logic [CRC_LEN-1:0] crc_of_raw();
	logic [CRC_LEN-1:0] crc;
	logic next_bit;
	crc = '0;
	foreach (raw_bits[i])
	begin
		next_bit = raw_bits[i] ^ crc[CRC_LEN-1];
		crc = {crc[CRC_LEN-2:0], 1'b0};
		if (next_bit)
			crc = crc ^ 15'h4599;
	end
	return crc;
endfunction

// Arbitration, control, data and CRC fields
function automatic void build_raw(logic [28:0] id, logic ide, logic rtr,
	logic [3:0] dlc, logic [63:0] data);
	logic [CRC_LEN-1:0] crc;
	raw_bits.delete();
	// SOF
	raw_bits.push_back(1'b0);
	if (ide)
	begin
		push_raw_field(id[28:18], ID_BASE_LEN);
		// SRR and IDE both recessive
		raw_bits.push_back(1'b1);
		raw_bits.push_back(1'b1);
		push_raw_field(id[17:0], ID_EXT_LEN);
		raw_bits.push_back(rtr);
		// r1, r0
		raw_bits.push_back(1'b0);
		raw_bits.push_back(1'b0);
	end
	else
	begin
		push_raw_field(id[10:0], ID_BASE_LEN);
		raw_bits.push_back(rtr);
		// IDE, r0
		raw_bits.push_back(1'b0);
		raw_bits.push_back(1'b0);
	end
	push_raw_field(dlc, DLC_LEN);
	raw_data_pos = raw_bits.size();
	push_raw_field(data, 8 * data_bytes(dlc, rtr));
	crc = crc_of_raw();
	push_raw_field(crc, CRC_LEN);
endfunction

// Corrupt one unstuffed bit, CRC stays as computed
function automatic void flip_raw(int index);
	raw_bits[index] = !raw_bits[index];
endfunction

// Complement bit after every run of five, the run restarts at the stuff bit
function automatic void stuff_raw();
	logic last;
	int run;
	wire_bits.delete();
	last = 1'b1;
	run = 0;
	foreach (raw_bits[i])
	begin
		wire_bits.push_back(raw_bits[i]);
		if (raw_bits[i] == last)
			run++;
		else
		begin
			last = raw_bits[i];
			run = 1;
		end
		if (run == STUFF_RUN)
		begin
			wire_bits.push_back(!last);
			last = !last;
			run = 1;
		end
	end
endfunction

// CRC delimiter, ACK slot, ACK delimiter, EOF and a full intermission
function automatic void append_tail(logic crc_delim, logic ack_slot);
	wire_bits.push_back(crc_delim);
	wire_bits.push_back(ack_slot);
	wire_bits.push_back(1'b1);
	repeat (EOF_LEN + INTERFRAME_LEN + 1)
		wire_bits.push_back(1'b1);
endfunction

// Remove one bus bit, e.g. a stuff bit
function automatic void drop_wire(int index);
	wire_bits.delete(index);
endfunction

// Good frame, acknowledged
function automatic void build_frame(logic [28:0] id, logic ide, logic rtr,
	logic [3:0] dlc, logic [63:0] data);
	build_raw(id, ide, rtr, dlc, data);
	stuff_raw();
	append_tail(1'b1, 1'b0);
endfunction

`endif

// ==== tb/can_rx_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module can_rx_tb
	import can_rx_pkg::*;
();

	localparam int RECOVERY_BITS = 10;

	logic clock;
	logic reset;
	logic rx_bit;
	logic sample_point;
	logic ack;
	logic req;
	logic overrun;
	can_id_t out_id;
	logic out_ide;
	logic out_rtr;
	logic [DLC_LEN-1:0] out_dlc;
	logic [MAX_DATA_BYTES*8-1:0] out_data;
	logic error;
	logic [1:0] error_code;

	// Monitor counters
	int error_count;
	logic [1:0] last_error_code;
	int req_rises;
	logic req_seen;
	logic [31:0] rng_state;

	`include "can_frame_builder.svh"

	can_rx #(
		.RECOVERY_BITS(RECOVERY_BITS)
	) dut0 (
		.clock(clock),
		.reset(reset),
		.rx_bit(rx_bit),
		.sample_point(sample_point),
		.ack(ack),
		.req(req),
		.overrun(overrun),
		.out_id(out_id),
		.out_ide(out_ide),
		.out_rtr(out_rtr),
		.out_dlc(out_dlc),
		.out_data(out_data),
		.error(error),
		.error_code(error_code)
	);

	// 8 ns period
	always #4 clock = !clock;

	// Outputs sampled mid-cycle
	always @(negedge clock)
	begin
		if (reset)
		begin
			error_count = 0;
			req_rises = 0;
			req_seen = 1'b0;
		end
		else
		begin
			if (error)
			begin
				error_count++;
				last_error_code = error_code;
			end
			if (req && !req_seen)
				req_rises++;
			req_seen = req;
		end
	end

	// ====================
	// Helpers
	// ====================
	function automatic logic [31:0] xorshift_next();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// Received bytes end up right-aligned
	function automatic logic [63:0] expected_data(logic [63:0] data, logic [3:0] dlc,
		logic rtr);
		int n;
		n = data_bytes(dlc, rtr);
		if (n == 8)
			return data;
		return data & ((64'd1 << (8 * n)) - 64'd1);
	endfunction

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		assert (got === expected)
		else
			fail_run($sformatf("Error at %0t ns: %s is 0x%0h, expected 0x%0h",
				$time, name, got, expected));
	endtask

	// One strobe and eight cycles per bit
	task automatic drive_bit(input logic value);
		@(posedge clock);
		#1;
		rx_bit = value;
		sample_point = 1'b1;
		@(posedge clock);
		#1;
		sample_point = 1'b0;
		repeat (6) @(posedge clock);
	endtask

	task automatic send_wire();
		foreach (wire_bits[i])
			drive_bit(wire_bits[i]);
	endtask

	task automatic send_idle(input int count);
		repeat (count) drive_bit(1'b1);
	endtask

	task automatic wait_for_req();
		int cycles;
		cycles = 0;
		while (!req && cycles < 400)
		begin
			@(negedge clock);
			cycles++;
		end
		assert (req)
		else
			fail_run("Timed out waiting for req from the DUT");
	endtask

	// Check every field and hold ack high until req falls
	task automatic take_frame(input logic [28:0] id, input logic ide, input logic rtr,
		input logic [3:0] dlc, input logic [63:0] data, input logic exp_overrun);
		int cycles;
		wait_for_req();
		@(negedge clock);
		check_value("out_ide", out_ide, ide);
		check_value("out_rtr", out_rtr, rtr);
		check_value("out_dlc", out_dlc, dlc);
		check_value("overrun", overrun, exp_overrun);
		if (ide)
		begin
			check_value("out_id.ext.base", out_id.ext.base, id[28:18]);
			check_value("out_id.ext.extension", out_id.ext.extension, id[17:0]);
		end
		else
		begin
			check_value("out_id.std.id", out_id.std.id, id[10:0]);
			check_value("out_id.std.pad", out_id.std.pad, 0);
		end
		check_value("out_data", out_data, expected_data(data, dlc, rtr));
		@(posedge clock);
		#1;
		ack = 1'b1;
		cycles = 0;
		while (req && cycles < 20)
		begin
			@(negedge clock);
			cycles++;
		end
		assert (!req)
		else
			fail_run("req stayed high after ack was raised");
	endtask

	task automatic release_ack();
		@(posedge clock);
		#1;
		ack = 1'b0;
	endtask

	// Full four-phase transfer of one frame
	task automatic consume_frame(input logic [28:0] id, input logic ide, input logic rtr,
		input logic [3:0] dlc, input logic [63:0] data, input logic exp_overrun);
		take_frame(id, ide, rtr, dlc, data, exp_overrun);
		release_ack();
	endtask

	// Random standard data frame as raw bits only
	task automatic pick_standard(output logic [28:0] id, output logic [3:0] dlc,
		output logic [63:0] data);
		logic [31:0] r;
		r = xorshift_next();
		id = {18'd0, r[10:0]};
		dlc = r[15:12];
		// Keep a data field to corrupt
		if (dlc == 4'd0)
			dlc = 4'd8;
		data = {xorshift_next(), xorshift_next()};
		build_raw(id, 1'b0, 1'b0, dlc, data);
	endtask

	task automatic send_standard(output logic [28:0] id, output logic [3:0] dlc,
		output logic [63:0] data);
		pick_standard(id, dlc, data);
		stuff_raw();
		append_tail(1'b1, 1'b0);
		send_wire();
	endtask

	// Send the bad frame in wire_bits and enough idle for recovery
	task automatic run_error_frame(input logic [1:0] code);
		int errors_before;
		int rises_before;
		errors_before = error_count;
		rises_before = req_rises;
		send_wire();
		send_idle(RECOVERY_BITS + 2);
		check_value("error pulses", error_count - errors_before, 1);
		check_value("error_code", last_error_code, code);
		check_value("req rises", req_rises - rises_before, 0);
	endtask

	// ====================
	// Directed tests
	// ====================
	task automatic test_standard_data();
		logic [28:0] id;
		logic [3:0] dlc;
		logic [63:0] data;
		int errors_before;
		errors_before = error_count;
		send_standard(id, dlc, data);
		consume_frame(id, 1'b0, 1'b0, dlc, data, 1'b0);
		check_value("error pulses", error_count - errors_before, 0);
	endtask

	task automatic test_extended_and_remote();
		logic [31:0] r;
		logic [28:0] id;
		logic [3:0] dlc;
		logic [63:0] data;
		r = xorshift_next();
		id = r[28:0];
		r = xorshift_next();
		dlc = r[3:0];
		data = {xorshift_next(), xorshift_next()};
		build_frame(id, 1'b1, 1'b0, dlc, data);
		send_wire();
		consume_frame(id, 1'b1, 1'b0, dlc, data, 1'b0);
		// Standard remote frame keeps its DLC and has no data field
		r = xorshift_next();
		id = {18'd0, r[10:0]};
		build_frame(id, 1'b0, 1'b1, 4'd5, data);
		send_wire();
		consume_frame(id, 1'b0, 1'b1, 4'd5, data, 1'b0);
	endtask

	task automatic test_stuff_error();
		// With an all-zero id the first stuff bit follows SOF and four id bits
		build_raw(29'd0, 1'b0, 1'b0, 4'd1, 64'ha5);
		stuff_raw();
		append_tail(1'b1, 1'b0);
		drop_wire(STUFF_RUN);
		run_error_frame(ERR_STUFF);
	endtask

	task automatic test_crc_form_ack_errors();
		logic [28:0] id;
		logic [3:0] dlc;
		logic [63:0] data;
		pick_standard(id, dlc, data);
		flip_raw(raw_data_pos + 2);
		stuff_raw();
		append_tail(1'b1, 1'b0);
		run_error_frame(ERR_CRC);
		// Dominant CRC delimiter
		pick_standard(id, dlc, data);
		stuff_raw();
		append_tail(1'b0, 1'b0);
		run_error_frame(ERR_FORM);
		// Nobody acknowledges
		pick_standard(id, dlc, data);
		stuff_raw();
		append_tail(1'b1, 1'b1);
		run_error_frame(ERR_ACK);
		send_standard(id, dlc, data);
		consume_frame(id, 1'b0, 1'b0, dlc, data, 1'b0);
	endtask

	task automatic test_back_pressure();
		logic [28:0] id_held;
		logic [3:0] dlc_held;
		logic [63:0] data_held;
		logic [28:0] id;
		logic [3:0] dlc;
		logic [63:0] data;
		int rises_before;
		send_standard(id_held, dlc_held, data_held);
		// Two frames complete while ack stays low
		send_standard(id, dlc, data);
		send_standard(id, dlc, data);
		check_value("req", req, 1'b1);
		consume_frame(id_held, 1'b0, 1'b0, dlc_held, data_held, 1'b0);
		send_standard(id, dlc, data);
		consume_frame(id, 1'b0, 1'b0, dlc, data, 1'b1);
		send_standard(id, dlc, data);
		take_frame(id, 1'b0, 1'b0, dlc, data, 1'b0);
		// Frame ends while ack is still high and gets dropped
		rises_before = req_rises;
		send_standard(id, dlc, data);
		check_value("req rises", req_rises - rises_before, 0);
		release_ack();
		send_standard(id, dlc, data);
		consume_frame(id, 1'b0, 1'b0, dlc, data, 1'b1);
	endtask

	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		rx_bit = 1'b1;
		sample_point = 1'b0;
		ack = 1'b0;
		rng_state = 32'd83139;
		error_count = 0;
		last_error_code = 2'd0;
		req_rises = 0;
		req_seen = 1'b0;
		repeat (16) @(posedge clock);
		#1;
		reset = 1'b0;
		send_idle(4);
		test_standard_data();
		test_extended_and_remote();
		test_stuff_error();
		test_crc_form_ack_errors();
		test_back_pressure();
		send_idle(2);
		if (dut0.u_buffer.handshake_check.violations == 0)
		begin
			$display("Simulation completed successfully");
			$finish;
		end
		else
			fail_run("Handshake assertions reported violations");
	end

endmodule

`default_nettype wire

// ==== tb/can_rx_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module can_rx_sva
	import can_rx_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic req,
	input logic ack,
	input can_id_t out_id,
	input logic out_ide,
	input logic out_rtr,
	input logic [DLC_LEN-1:0] out_dlc,
	input logic [MAX_DATA_BYTES*8-1:0] out_data
);

	// Failed assertions so far
	int violations = 0;

	// ====================
	// Four-phase handshake
	// ====================
	req_held: assert property (@(posedge clock) disable iff (reset)
		req && !ack |=> req)
	else
	begin
		$error("req fell before ack rose");
		violations++;
	end

	// Consumer reads a frozen frame
	fields_stable: assert property (@(posedge clock) disable iff (reset)
		req |=> !req || $stable({out_id, out_ide, out_rtr, out_dlc, out_data}))
	else
	begin
		$error("output fields changed while req was high");
		violations++;
	end

	req_rise_ack_low: assert property (@(posedge clock) disable iff (reset)
		$rose(req) |-> !ack)
	else
	begin
		$error("req rose while ack was still high");
		violations++;
	end

endmodule

bind can_frame_buffer can_rx_sva handshake_check (
	.clock(clock),
	.reset(reset),
	.req(req),
	.ack(ack),
	.out_id(out_id),
	.out_ide(out_ide),
	.out_rtr(out_rtr),
	.out_dlc(out_dlc),
	.out_data(out_data)
);

`default_nettype wire

// ==== hdl/can_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module can_rx
	import can_rx_pkg::*;
#(
	parameter int RECOVERY_BITS = 10
)
(
	input logic clock,
	input logic reset,
	input logic rx_bit,
	input logic sample_point,
	input logic ack,
	output logic req,
	output logic overrun,
	output can_id_t out_id,
	output logic out_ide,
	output logic out_rtr,
	output logic [DLC_LEN-1:0] out_dlc,
	output logic [MAX_DATA_BYTES*8-1:0] out_data,
	output logic error,
	output logic [1:0] error_code
);

	// Stage 1 to stage 2
	logic bit_valid;
	logic bit_value;
	logic stuff_error;
	logic stuff_active;

	// Stage 2 to stage 3
	logic frame_done;
	logic frame_ide;
	logic frame_rtr;
	can_id_t frame_id;
	logic [DLC_LEN-1:0] frame_dlc;
	logic [MAX_DATA_BYTES*8-1:0] frame_data;

	can_destuffer u_destuffer (
		.clock(clock),
		.reset(reset),
		.rx_bit(rx_bit),
		.sample_point(sample_point),
		.stuff_active(stuff_active),
		.bit_valid(bit_valid),
		.bit_value(bit_value),
		.stuff_error(stuff_error)
	);

	can_field_parser #(
		.RECOVERY_BITS(RECOVERY_BITS)
	) u_parser (
		.clock(clock),
		.reset(reset),
		.bit_valid(bit_valid),
		.bit_value(bit_value),
		.stuff_error(stuff_error),
		.stuff_active(stuff_active),
		.frame_done(frame_done),
		.frame_ide(frame_ide),
		.frame_rtr(frame_rtr),
		.error(error),
		.error_code(error_code),
		.frame_id(frame_id),
		.frame_dlc(frame_dlc),
		.frame_data(frame_data)
	);

	can_frame_buffer u_buffer (
		.clock(clock),
		.reset(reset),
		.frame_done(frame_done),
		.frame_ide(frame_ide),
		.frame_rtr(frame_rtr),
		.ack(ack),
		.frame_id(frame_id),
		.frame_dlc(frame_dlc),
		.frame_data(frame_data),
		.req(req),
		.overrun(overrun),
		.out_ide(out_ide),
		.out_rtr(out_rtr),
		.out_id(out_id),
		.out_dlc(out_dlc),
		.out_data(out_data)
	);

endmodule

`default_nettype wire

// ==== hdl/can_frame_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module can_frame_buffer
	import can_rx_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic frame_done,
	input logic frame_ide,
	input logic frame_rtr,
	input logic ack,
	input can_id_t frame_id,
	input logic [DLC_LEN-1:0] frame_dlc,
	input logic [MAX_DATA_BYTES*8-1:0] frame_data,
	output logic req,
	output logic overrun,
	output logic out_ide,
	output logic out_rtr,
	output can_id_t out_id,
	output logic [DLC_LEN-1:0] out_dlc,
	output logic [MAX_DATA_BYTES*8-1:0] out_data
);

	// Four-phase states
	localparam logic [1:0] B_EMPTY = 2'd0;
	localparam logic [1:0] B_FULL = 2'd1;
	localparam logic [1:0] B_DRAIN = 2'd2;

	logic [1:0] state;
	// A frame was lost since the last delivery
	logic overrun_pend;
	logic load;

	assign req = (state == B_FULL);
	assign load = frame_done && (state == B_EMPTY);

	// ====================
	// Handshake
	// ====================
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= B_EMPTY;
			overrun <= 1'b0;
			overrun_pend <= 1'b0;
		end
		else
		begin
			// Busy buffer drops the new frame
			if (frame_done && state != B_EMPTY)
				overrun_pend <= 1'b1;
			case (state)
				B_EMPTY:
					if (frame_done)
					begin
						state <= B_FULL;
						overrun <= overrun_pend;
						overrun_pend <= 1'b0;
					end
				B_FULL:
					if (ack)
					begin
						state <= B_DRAIN;
						overrun <= 1'b0;
					end
				B_DRAIN:
					// Wait for ack to fall before the next req
					if (!ack)
						state <= B_EMPTY;
				default:
					state <= B_EMPTY;
			endcase
		end
	end

	// Held fields
	always_ff @(posedge clock)
	begin
		if (load)
		begin
			out_ide <= frame_ide;
			out_rtr <= frame_rtr;
			out_id <= frame_id;
			out_dlc <= frame_dlc;
			out_data <= frame_data;
		end
	end

endmodule

`default_nettype wire

// ==== frame_parser/can_field_parser.sv ====
`timescale 1ns/1ps
`default_nettype none

module can_field_parser
	import can_rx_pkg::*;
#(
	parameter int RECOVERY_BITS = 10
)
(
	input logic clock,
	input logic reset,
	input logic bit_valid,
	input logic bit_value,
	input logic stuff_error,
	output logic stuff_active,
	output logic frame_done,
	output logic frame_ide,
	output logic frame_rtr,
	output logic error,
	output logic [1:0] error_code,
	output can_id_t frame_id,
	output logic [DLC_LEN-1:0] frame_dlc,
	output logic [MAX_DATA_BYTES*8-1:0] frame_data
);

	localparam int REC_W = $clog2(RECOVERY_BITS + 1);

	// ====================
	// State codes, in bus order
	// ====================
	localparam logic [4:0] S_IDLE = 5'd0;
	localparam logic [4:0] S_ID_A = 5'd1;
	localparam logic [4:0] S_SRR_RTR = 5'd2;
	localparam logic [4:0] S_IDE = 5'd3;
	localparam logic [4:0] S_ID_B = 5'd4;
	localparam logic [4:0] S_RTR = 5'd5;
	localparam logic [4:0] S_R1 = 5'd6;
	localparam logic [4:0] S_R0 = 5'd7;
	localparam logic [4:0] S_DLC = 5'd8;
	localparam logic [4:0] S_DATA = 5'd9;
	localparam logic [4:0] S_CRC = 5'd10;
	localparam logic [4:0] S_CRC_DELIM = 5'd11;
	localparam logic [4:0] S_ACK_SLOT = 5'd12;
	localparam logic [4:0] S_ACK_DELIM = 5'd13;
	localparam logic [4:0] S_EOF = 5'd14;
	localparam logic [4:0] S_INTERFRAME = 5'd15;
	localparam logic [4:0] S_RECOVER = 5'd16;

	logic [4:0] state;
	logic [4:0] state_next;
	// Bits seen in the current field
	logic [6:0] bit_cnt;
	// Consecutive recessive bits while recovering
	logic [REC_W-1:0] rec_cnt;
	logic fault;
	logic [1:0] fault_code;
	logic [ID_BASE_LEN-1:0] id_a;
	logic srr_rtr;
	logic [CRC_LEN-1:0] rx_crc;
	logic [CRC_LEN-1:0] crc_value;
	logic crc_clear;
	logic crc_step;
	logic [DLC_LEN-1:0] dlc_next;
	logic [DLC_LEN-1:0] dlc_clamped;
	logic [6:0] data_bits;

	// Stuffing covers SOF to CRC, plus a stuff bit trailing the CRC
	assign stuff_active = (state >= S_ID_A) && (state <= S_CRC_DELIM);

	// SOF is dominant, so shifting it into a cleared LFSR keeps zero
	assign crc_clear = bit_valid && (state == S_IDLE) && !bit_value;
	assign crc_step = bit_valid && !stuff_error && (state >= S_ID_A) && (state <= S_DATA);

	// DLC values 9..15 mean 8 bytes
	assign dlc_next = {frame_dlc[DLC_LEN-2:0], bit_value};
	assign dlc_clamped = (frame_dlc > MAX_DATA_BYTES) ? DLC_LEN'(MAX_DATA_BYTES) : frame_dlc;
	assign data_bits = {dlc_clamped[3:0], 3'b000};

	can_crc15 u_crc (
		.clock(clock),
		.reset(reset),
		.crc_clear(crc_clear),
		.crc_step(crc_step),
		.crc_bit(bit_value),
		.crc_value(crc_value)
	);

	// ====================
	// Next state and checks
	// ====================
	always_comb
	begin
		state_next = state;
		fault = 1'b0;
		fault_code = ERR_FORM;
		case (state)
			S_IDLE:
				if (!bit_value)
					state_next = S_ID_A;
			S_ID_A:
				if (bit_cnt == 7'(ID_BASE_LEN - 1))
					state_next = S_SRR_RTR;
			S_SRR_RTR:
				state_next = S_IDE;
			S_IDE:
				if (bit_value)
				begin
					// Extended frame, SRR must have been recessive
					fault = !srr_rtr;
					state_next = S_ID_B;
				end
				else
					state_next = S_R0;
			S_ID_B:
				if (bit_cnt == 7'(ID_EXT_LEN - 1))
					state_next = S_RTR;
			S_RTR:
				state_next = S_R1;
			S_R1:
				state_next = S_R0;
			S_R0:
				state_next = S_DLC;
			S_DLC:
				if (bit_cnt == 7'(DLC_LEN - 1))
				begin
					// Remote frames and DLC 0 carry no data
					if (frame_rtr || dlc_next == '0)
						state_next = S_CRC;
					else
						state_next = S_DATA;
				end
			S_DATA:
				if (bit_cnt == data_bits - 7'd1)
					state_next = S_CRC;
			S_CRC:
				if (bit_cnt == 7'(CRC_LEN - 1))
					state_next = S_CRC_DELIM;
			S_CRC_DELIM:
			begin
				if (!bit_value)
					fault = 1'b1;
				else if (rx_crc != crc_value)
				begin
					fault = 1'b1;
					fault_code = ERR_CRC;
				end
				state_next = S_ACK_SLOT;
			end
			S_ACK_SLOT:
			begin
				// Some node must acknowledge
				if (bit_value)
				begin
					fault = 1'b1;
					fault_code = ERR_ACK;
				end
				state_next = S_ACK_DELIM;
			end
			S_ACK_DELIM:
			begin
				fault = !bit_value;
				state_next = S_EOF;
			end
			S_EOF:
				if (!bit_value)
					fault = 1'b1;
				else if (bit_cnt == 7'(EOF_LEN - 1))
					state_next = S_INTERFRAME;
			S_INTERFRAME:
				// Dominant here would be an overload flag
				if (!bit_value)
					fault = 1'b1;
				else if (bit_cnt == 7'(INTERFRAME_LEN - 1))
					state_next = S_IDLE;
			S_RECOVER:
				if (bit_value && rec_cnt == REC_W'(RECOVERY_BITS - 1))
					state_next = S_IDLE;
			default:
				state_next = S_IDLE;
		endcase
		// Stuff violation wins over anything in the field
		if (stuff_error)
		begin
			fault = 1'b1;
			fault_code = ERR_STUFF;
		end
		if (fault)
			state_next = S_RECOVER;
	end

	// ====================
	// Control registers
	// ====================
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= S_IDLE;
			bit_cnt <= '0;
			rec_cnt <= '0;
			frame_done <= 1'b0;
			error <= 1'b0;
			error_code <= ERR_STUFF;
		end
		else
		begin
			frame_done <= 1'b0;
			error <= 1'b0;
			if (bit_valid)
			begin
				state <= state_next;
				// Counter restarts with every new field
				if (state_next != state)
					bit_cnt <= '0;
				else
					bit_cnt <= bit_cnt + 7'd1;
				if (state != S_RECOVER || !bit_value)
					rec_cnt <= '0;
				else
					rec_cnt <= rec_cnt + 1'b1;
				// Last recessive EOF bit completes the frame
				frame_done <= (state == S_EOF) && (state_next == S_INTERFRAME);
				if (fault)
				begin
					error <= 1'b1;
					error_code <= fault_code;
				end
			end
		end
	end

	// ====================
	// Field shift registers
	// ====================
	always_ff @(posedge clock)
	begin
		if (bit_valid && !stuff_error)
		begin
			case (state)
				S_IDLE:
					// Short payloads end up right-aligned
					if (!bit_value)
						frame_data <= '0;
				S_ID_A:
					id_a <= {id_a[ID_BASE_LEN-2:0], bit_value};
				S_SRR_RTR:
					srr_rtr <= bit_value;
				S_IDE:
				begin
					frame_ide <= bit_value;
					if (bit_value)
						frame_id.ext.base <= id_a;
					else
					begin
						frame_id.std.pad <= '0;
						frame_id.std.id <= id_a;
						// Standard frame, that bit was RTR
						frame_rtr <= srr_rtr;
					end
				end
				S_ID_B:
					frame_id.ext.extension <=
						{frame_id.ext.extension[ID_EXT_LEN-2:0], bit_value};
				S_RTR:
					frame_rtr <= bit_value;
				S_DLC:
					frame_dlc <= dlc_next;
				S_DATA:
					frame_data <= {frame_data[MAX_DATA_BYTES*8-2:0], bit_value};
				S_CRC:
					rx_crc <= {rx_crc[CRC_LEN-2:0], bit_value};
				default:
				begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== frame_parser/can_crc15.sv ====
`timescale 1ns/1ps
`default_nettype none

module can_crc15
	import can_rx_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic crc_clear,
	input logic crc_step,
	input logic crc_bit,
	output logic [CRC_LEN-1:0] crc_value
);

	// Feedback is the incoming bit against the register MSB
	logic feedback;

	assign feedback = crc_bit ^ crc_value[CRC_LEN-1];

	// ====================
	// Serial LFSR
	// ====================
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			crc_value <= '0;
		else if (crc_clear)
			crc_value <= '0;
		else if (crc_step)
		begin
			if (feedback)
				crc_value <= {crc_value[CRC_LEN-2:0], 1'b0} ^ CRC_POLY;
			else
				crc_value <= {crc_value[CRC_LEN-2:0], 1'b0};
		end
	end

endmodule

`default_nettype wire

// ==== hdl/can_destuffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module can_destuffer
	import can_rx_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic rx_bit,
	input logic sample_point,
	input logic stuff_active,
	output logic bit_valid,
	output logic bit_value,
	output logic stuff_error
);

	logic last_bit;
	// Length of the current run of equal bits
	logic [$clog2(STUFF_RUN+1)-1:0] run_count;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			last_bit <= 1'b1;
			run_count <= '0;
			bit_valid <= 1'b0;
			bit_value <= 1'b1;
			stuff_error <= 1'b0;
		end
		else
		begin
			// Single-cycle pulses by default
			bit_valid <= 1'b0;
			stuff_error <= 1'b0;
			if (sample_point)
			begin
				bit_value <= rx_bit;
				last_bit <= rx_bit;
				if (!stuff_active)
				begin
					// Outside the stuffed span, every bit starts a fresh run
					run_count <= 1;
					bit_valid <= 1'b1;
				end
				else if (rx_bit == last_bit)
				begin
					// Sixth equal bit is a stuff violation
					if (run_count == STUFF_RUN)
						stuff_error <= 1'b1;
					else
						run_count <= run_count + 1'b1;
					bit_valid <= 1'b1;
				end
				else
				begin
					run_count <= 1;
					// Complement after a full run is the stuff bit, drop it
					bit_valid <= (run_count != STUFF_RUN);
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== common/can_rx_pkg.sv ====
`default_nettype none

package can_rx_pkg;

	// ====================
	// Field lengths in bits
	// ====================
	localparam int ID_BASE_LEN = 11;
	localparam int ID_EXT_LEN = 18;
	localparam int DLC_LEN = 4;
	localparam int CRC_LEN = 15;
	localparam int EOF_LEN = 7;
	// Third intermission bit may already carry the next SOF
	localparam int INTERFRAME_LEN = 2;
	localparam int MAX_DATA_BYTES = 8;
	// Equal bits before a complementary stuff bit
	localparam int STUFF_RUN = 5;

	// CAN generator x^15+x^14+x^10+x^8+x^7+x^4+x^3+1
	localparam logic [CRC_LEN-1:0] CRC_POLY = 15'h4599;

	// Error codes
	localparam logic [1:0] ERR_STUFF = 2'd0;
	localparam logic [1:0] ERR_FORM = 2'd1;
	localparam logic [1:0] ERR_ACK = 2'd2;
	localparam logic [1:0] ERR_CRC = 2'd3;

	// One identifier word, read by IDE
	typedef union packed {
		// Standard frame, 11-bit id in the low bits
		struct packed {
			logic [ID_EXT_LEN-1:0] pad;
			logic [ID_BASE_LEN-1:0] id;
		} std;
		// Extended frame, base id above the extension
		struct packed {
			logic [ID_BASE_LEN-1:0] base;
			logic [ID_EXT_LEN-1:0] extension;
		} ext;
	} can_id_t;

endpackage

`default_nettype wire
